// File: source/pixelPkg.sv
package pixelPkg;

	// --------------------------------------------------
	// Channel widths
	// --------------------------------------------------
	// Gouraud colour from the front end
	localparam int GOURAUD_BITS = 8;
	// Video memory channel
	localparam int CHANNEL_BITS = 5;

	typedef logic [GOURAUD_BITS-1:0] colour8_t;
	typedef logic [CHANNEL_BITS-1:0] colour5_t;

	// Saturation level of a video memory channel
	localparam colour5_t CHANNEL_MAX = 5'd31;

	// --------------------------------------------------
	// Stored pixel layout
	// --------------------------------------------------
	// Mask bit on top, then blue, green, red
	typedef logic [15:0] pixelWord_t;
	localparam int RED_LSB = 0;
	localparam int GREEN_LSB = 5;
	localparam int BLUE_LSB = 10;
	localparam int MASK_BIT = 15;

	// Semi-transparency modes, same encoding as the GPU register
	typedef enum logic [1:0] {
		AVERAGE = 2'd0,
		ADD = 2'd1,
		SUBTRACT = 2'd2,
		ADD_QUARTER = 2'd3
	} blendMode_t;

endpackage

// File: source/blockPkg.sv
package blockPkg;

	// --------------------------------------------------
	// Screen coordinates
	// --------------------------------------------------
	// X is doubled, bit 0 picks the side of the pair
	typedef logic [9:0] screenX_t;
	typedef logic [8:0] screenY_t;

	// Y above X bits 9..4
	typedef logic [14:0] blockAdr_t;

	// --------------------------------------------------
	// Block geometry
	// --------------------------------------------------
	localparam int PAIRS_PER_BLOCK = 8;
	localparam int PIXELS_PER_BLOCK = 2 * PAIRS_PER_BLOCK;
	// Width of one stored word inside the block
	localparam int WORD_BITS = 16;

	typedef logic [2:0] slotIndex_t;
	typedef logic [PIXELS_PER_BLOCK*WORD_BITS-1:0] blockData_t;
	typedef logic [PIXELS_PER_BLOCK-1:0] blockMask_t;

	// Block transition code from the front end
	typedef logic [1:0] transition_t;
	localparam int TRANS_START = 0;
	localparam int TRANS_END = 1;

endpackage

// File: source/pairStage.sv
`timescale 1ns/1ps

module pairStage (
	input  logic                   clk,
	input  logic                   i_rst,
	input  logic                   i_pause,
	input  blockPkg::transition_t  i_transition,
	input  blockPkg::screenX_t     i_scrX,
	input  blockPkg::screenY_t     i_scrY,
	input  pixelPkg::colour8_t     i_rL,
	input  pixelPkg::colour8_t     i_gL,
	input  pixelPkg::colour8_t     i_bL,
	input  pixelPkg::colour8_t     i_rR,
	input  pixelPkg::colour8_t     i_gR,
	input  pixelPkg::colour8_t     i_bR,
	input  logic                   i_validL,
	input  logic                   i_validR,
	input  logic                   i_maskL,
	input  logic                   i_maskR,
	output blockPkg::transition_t  o_transition,
	output blockPkg::screenX_t     o_scrX,
	output blockPkg::screenY_t     o_scrY,
	output pixelPkg::colour8_t     o_rL,
	output pixelPkg::colour8_t     o_gL,
	output pixelPkg::colour8_t     o_bL,
	output pixelPkg::colour8_t     o_rR,
	output pixelPkg::colour8_t     o_gR,
	output pixelPkg::colour8_t     o_bR,
	output logic                   o_validL,
	output logic                   o_validR,
	output logic                   o_maskL,
	output logic                   o_maskR
);

	// --------------------------------------------------
	// Control part, cleared on reset
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (i_rst) begin
			o_transition <= '0;
			o_validL <= 1'b0;
			o_validR <= 1'b0;
		end else if (!i_pause) begin
			o_transition <= i_transition;
			o_validL <= i_validL;
			o_validR <= i_validR;
		end
	end

	// Payload, held as is while paused
	always_ff @(posedge clk) begin
		if (!i_pause) begin
			o_scrX <= i_scrX;
			o_scrY <= i_scrY;
			o_rL <= i_rL;
			o_gL <= i_gL;
			o_bL <= i_bL;
			o_rR <= i_rR;
			o_gR <= i_gR;
			o_bR <= i_bR;
			o_maskL <= i_maskL;
			o_maskR <= i_maskR;
		end
	end

	// Front end never marks one pair as both start and end of a block
	assertTransition: assert property (@(posedge clk) disable iff (i_rst)
		!(i_transition[blockPkg::TRANS_START] && i_transition[blockPkg::TRANS_END]));

endmodule

// File: source/pixelBlender.sv
`timescale 1ns/1ps

module pixelBlender (
	input  pixelPkg::colour8_t    i_r,
	input  pixelPkg::colour8_t    i_g,
	input  pixelPkg::colour8_t    i_b,
	input  logic                  i_maskBit,
	input  logic                  i_blendEnable,
	input  pixelPkg::blendMode_t  i_blendMode,
	input  pixelPkg::pixelWord_t  i_background,
	output pixelPkg::pixelWord_t  o_pixel
);

	// --------------------------------------------------
	// One channel, blend rule and clamp
	// --------------------------------------------------
	function automatic pixelPkg::colour5_t blendChannel(
		input pixelPkg::colour5_t bg,
		input pixelPkg::colour5_t fg,
		input pixelPkg::blendMode_t mode
	);
		// Bit 6 flags a negative subtract, bit 5 a carry past 31
		logic [6:0] bgExt;
		logic [6:0] fgExt;
		logic [6:0] sum;
		pixelPkg::colour5_t result;
		bgExt = {2'b00, bg};
		fgExt = {2'b00, fg};
		case (mode)
			pixelPkg::AVERAGE:     sum = (bgExt >> 1) + (fgExt >> 1);
			pixelPkg::ADD:         sum = bgExt + fgExt;
			pixelPkg::SUBTRACT:    sum = bgExt - fgExt;
			pixelPkg::ADD_QUARTER: sum = bgExt + (fgExt >> 2);
			default:               sum = fgExt;
		endcase
		// Clamp to 0
		if (sum[6]) begin
			result = '0;
		end else if (sum > {2'b00, pixelPkg::CHANNEL_MAX}) begin
			// Saturate
			result = pixelPkg::CHANNEL_MAX;
		end else begin
			result = sum[pixelPkg::CHANNEL_BITS-1:0];
		end
		return result;
	endfunction

	// Foreground keeps the top 5 Gouraud bits
	pixelPkg::colour5_t fgR;
	pixelPkg::colour5_t fgG;
	pixelPkg::colour5_t fgB;
	// Background channels from the block buffer
	pixelPkg::colour5_t bgR;
	pixelPkg::colour5_t bgG;
	pixelPkg::colour5_t bgB;

	assign fgR = i_r[pixelPkg::GOURAUD_BITS-1 -: pixelPkg::CHANNEL_BITS];
	assign fgG = i_g[pixelPkg::GOURAUD_BITS-1 -: pixelPkg::CHANNEL_BITS];
	assign fgB = i_b[pixelPkg::GOURAUD_BITS-1 -: pixelPkg::CHANNEL_BITS];

	assign bgR = i_background[pixelPkg::RED_LSB +: pixelPkg::CHANNEL_BITS];
	assign bgG = i_background[pixelPkg::GREEN_LSB +: pixelPkg::CHANNEL_BITS];
	assign bgB = i_background[pixelPkg::BLUE_LSB +: pixelPkg::CHANNEL_BITS];

	// --------------------------------------------------
	// Output word
	// --------------------------------------------------
	always_comb begin
		o_pixel = '0;
		if (i_blendEnable) begin
			o_pixel[pixelPkg::RED_LSB +: pixelPkg::CHANNEL_BITS] = blendChannel(bgR, fgR, i_blendMode);
			o_pixel[pixelPkg::GREEN_LSB +: pixelPkg::CHANNEL_BITS] = blendChannel(bgG, fgG, i_blendMode);
			o_pixel[pixelPkg::BLUE_LSB +: pixelPkg::CHANNEL_BITS] = blendChannel(bgB, fgB, i_blendMode);
		end else begin
			// Opaque, plain conversion
			o_pixel[pixelPkg::RED_LSB +: pixelPkg::CHANNEL_BITS] = fgR;
			o_pixel[pixelPkg::GREEN_LSB +: pixelPkg::CHANNEL_BITS] = fgG;
			o_pixel[pixelPkg::BLUE_LSB +: pixelPkg::CHANNEL_BITS] = fgB;
		end
		// Mask bit passes through, background mask ignored
		o_pixel[pixelPkg::MASK_BIT] = i_maskBit;
	end

endmodule

// File: source/blockBuffer.sv
`timescale 1ns/1ps

module blockBuffer (
	input  logic                   clk,
	input  logic                   i_rst,
	input  logic                   i_pause,
	input  logic                   i_flushClearMask,
	input  blockPkg::transition_t  i_transition,
	input  blockPkg::screenX_t     i_scrX,
	input  blockPkg::screenY_t     i_scrY,
	input  logic                   i_validL,
	input  logic                   i_validR,
	input  pixelPkg::pixelWord_t   i_pixelL,
	input  pixelPkg::pixelWord_t   i_pixelR,
	input  logic                   i_importStrobe,
	input  blockPkg::blockData_t   i_importBlock,
	output pixelPkg::pixelWord_t   o_backgroundL,
	output pixelPkg::pixelWord_t   o_backgroundR,
	output logic                   o_stencilWriteSig,
	output blockPkg::blockAdr_t    o_stencilWriteAdr,
	output blockPkg::blockAdr_t    o_loadAdr,
	output blockPkg::blockAdr_t    o_saveAdr,
	output blockPkg::blockMask_t   o_stencilWriteMask,
	output blockPkg::blockMask_t   o_stencilWriteValue,
	output blockPkg::blockData_t   o_exportBlock,
	output blockPkg::blockMask_t   o_exportMask
);

	blockPkg::blockData_t cacheBlock;
	blockPkg::blockMask_t cacheMask;
	blockPkg::blockAdr_t lastWriteAdr;
	blockPkg::blockAdr_t writeAdr;
	blockPkg::slotIndex_t slot;
	// Word index of each side inside the block
	logic [3:0] wordL;
	logic [3:0] wordR;
	logic writeL;
	logic writeR;
	logic clearMask;

	// --------------------------------------------------
	// Pair slot and background read
	// --------------------------------------------------
	assign slot = i_scrX[3:1];
	assign wordL = {slot, 1'b0};
	assign wordR = {slot, 1'b1};

	assign o_backgroundL = cacheBlock[wordL*blockPkg::WORD_BITS +: blockPkg::WORD_BITS];
	assign o_backgroundR = cacheBlock[wordR*blockPkg::WORD_BITS +: blockPkg::WORD_BITS];

	// Block address of the pair in the stage
	assign writeAdr = {i_scrY, i_scrX[9:4]};

	// --------------------------------------------------
	// Write control, all frozen on pause
	// --------------------------------------------------
	// Block end seen in the stage, save the block now
	assign o_stencilWriteSig = i_transition[blockPkg::TRANS_END] & ~i_pause;
	assign clearMask = (o_stencilWriteSig | i_flushClearMask) & ~i_pause;
	// No texels here, a valid pixel is always written
	assign writeL = i_validL & ~i_pause;
	assign writeR = i_validR & ~i_pause;

	// Block data, pixel writes win over the import
	always_ff @(posedge clk) begin
		if (i_importStrobe) begin
			cacheBlock <= i_importBlock;
		end
		if (writeL) begin
			cacheBlock[wordL*blockPkg::WORD_BITS +: blockPkg::WORD_BITS] <= i_pixelL;
		end
		if (writeR) begin
			cacheBlock[wordR*blockPkg::WORD_BITS +: blockPkg::WORD_BITS] <= i_pixelR;
		end
	end

	// Mask and last block address
	always_ff @(posedge clk) begin
		if (i_rst) begin
			cacheMask <= '0;
			lastWriteAdr <= '0;
		end else begin
			// Clear first, a pixel of the new block still lands this edge
			if (clearMask) begin
				cacheMask <= '0;
			end
			if (writeL) begin
				cacheMask[wordL] <= 1'b1;
			end
			if (writeR) begin
				cacheMask[wordR] <= 1'b1;
			end
			if (writeL | writeR) begin
				lastWriteAdr <= writeAdr;
			end
		end
	end

	// --------------------------------------------------
	// Export side
	// --------------------------------------------------
	// Mask bit of every stored word
	always_comb begin
		for (int w = 0; w < blockPkg::PIXELS_PER_BLOCK; w++) begin
			o_stencilWriteValue[w] = cacheBlock[w*blockPkg::WORD_BITS + pixelPkg::MASK_BIT];
		end
	end

	assign o_stencilWriteMask = cacheMask;
	assign o_stencilWriteAdr = lastWriteAdr;
	assign o_saveAdr = lastWriteAdr;
	assign o_loadAdr = writeAdr;
	assign o_exportBlock = cacheBlock;
	assign o_exportMask = cacheMask;

	// A held pipeline keeps its mask and last block address
	assertHoldOnPause: assert property (@(posedge clk) disable iff (i_rst)
		i_pause |=> $stable(cacheMask) && $stable(lastWriteAdr));

endmodule

// File: source/gpuBackend.sv
`timescale 1ns/1ps

module gpuBackend (
	input  logic                   clk,
	input  logic                   i_rst,
	input  logic                   i_pause,
	input  logic                   i_flushClearMask,
	input  logic                   i_blendEnable,
	input  pixelPkg::blendMode_t   i_blendMode,
	input  blockPkg::transition_t  i_transition,
	input  blockPkg::screenX_t     i_scrX,
	input  blockPkg::screenY_t     i_scrY,
	input  pixelPkg::colour8_t     i_rL,
	input  pixelPkg::colour8_t     i_gL,
	input  pixelPkg::colour8_t     i_bL,
	input  pixelPkg::colour8_t     i_rR,
	input  pixelPkg::colour8_t     i_gR,
	input  pixelPkg::colour8_t     i_bR,
	input  logic                   i_validL,
	input  logic                   i_validR,
	input  logic                   i_maskL,
	input  logic                   i_maskR,
	input  logic                   i_importStrobe,
	input  blockPkg::blockData_t   i_importBlock,
	output logic                   o_stencilWriteSig,
	output blockPkg::blockAdr_t    o_stencilWriteAdr,
	output blockPkg::blockMask_t   o_stencilWriteMask,
	output blockPkg::blockMask_t   o_stencilWriteValue,
	output blockPkg::blockAdr_t    o_loadAdr,
	output blockPkg::blockAdr_t    o_saveAdr,
	output blockPkg::blockData_t   o_exportBlock,
	output blockPkg::blockMask_t   o_exportMask
);

	// Stage outputs
	blockPkg::transition_t sTransition;
	blockPkg::screenX_t sScrX;
	blockPkg::screenY_t sScrY;
	pixelPkg::colour8_t sRL;
	pixelPkg::colour8_t sGL;
	pixelPkg::colour8_t sBL;
	pixelPkg::colour8_t sRR;
	pixelPkg::colour8_t sGR;
	pixelPkg::colour8_t sBR;
	logic sValidL;
	logic sValidR;
	logic sMaskL;
	logic sMaskR;
	// Background words and blended results per side
	pixelPkg::pixelWord_t backgroundL;
	pixelPkg::pixelWord_t backgroundR;
	pixelPkg::pixelWord_t pixelL;
	pixelPkg::pixelWord_t pixelR;

	// --------------------------------------------------
	// Pair register
	// --------------------------------------------------
	pairStage u_stage (
		.clk(clk), .i_rst(i_rst), .i_pause(i_pause),
		.i_transition(i_transition), .i_scrX(i_scrX), .i_scrY(i_scrY),
		.i_rL(i_rL), .i_gL(i_gL), .i_bL(i_bL),
		.i_rR(i_rR), .i_gR(i_gR), .i_bR(i_bR),
		.i_validL(i_validL), .i_validR(i_validR),
		.i_maskL(i_maskL), .i_maskR(i_maskR),
		.o_transition(sTransition), .o_scrX(sScrX), .o_scrY(sScrY),
		.o_rL(sRL), .o_gL(sGL), .o_bL(sBL),
		.o_rR(sRR), .o_gR(sGR), .o_bR(sBR),
		.o_validL(sValidL), .o_validR(sValidR),
		.o_maskL(sMaskL), .o_maskR(sMaskR)
	);

	// Left pixel, even word of the slot
	pixelBlender u_blendL (
		.i_r(sRL), .i_g(sGL), .i_b(sBL), .i_maskBit(sMaskL),
		.i_blendEnable(i_blendEnable), .i_blendMode(i_blendMode),
		.i_background(backgroundL), .o_pixel(pixelL)
	);

	// Right pixel, odd word of the slot
	pixelBlender u_blendR (
		.i_r(sRR), .i_g(sGR), .i_b(sBR), .i_maskBit(sMaskR),
		.i_blendEnable(i_blendEnable), .i_blendMode(i_blendMode),
		.i_background(backgroundR), .o_pixel(pixelR)
	);

	// --------------------------------------------------
	// Block buffer and write back
	// --------------------------------------------------
	blockBuffer u_buffer (
		.clk(clk), .i_rst(i_rst), .i_pause(i_pause),
		.i_flushClearMask(i_flushClearMask), .i_transition(sTransition),
		.i_scrX(sScrX), .i_scrY(sScrY),
		.i_validL(sValidL), .i_validR(sValidR),
		.i_pixelL(pixelL), .i_pixelR(pixelR),
		.i_importStrobe(i_importStrobe), .i_importBlock(i_importBlock),
		.o_backgroundL(backgroundL), .o_backgroundR(backgroundR),
		.o_stencilWriteSig(o_stencilWriteSig), .o_stencilWriteAdr(o_stencilWriteAdr),
		.o_loadAdr(o_loadAdr), .o_saveAdr(o_saveAdr),
		.o_stencilWriteMask(o_stencilWriteMask), .o_stencilWriteValue(o_stencilWriteValue),
		.o_exportBlock(o_exportBlock), .o_exportMask(o_exportMask)
	);

endmodule

// File: dv/tbGpuBackend.sv
`timescale 1ns/1ps

module tbGpuBackend;

	// One table row per clock
	localparam int NROWS = 23;
	// Reset plus table plus margin
	localparam int CYCLE_LIMIT = NROWS + 20;

	logic clk;
	logic i_rst;
	logic i_pause;
	logic i_flushClearMask;
	logic i_blendEnable;
	pixelPkg::blendMode_t i_blendMode;
	blockPkg::transition_t i_transition;
	blockPkg::screenX_t i_scrX;
	blockPkg::screenY_t i_scrY;
	// Side 0 is left, side 1 is right
	pixelPkg::colour8_t inR [2];
	pixelPkg::colour8_t inG [2];
	pixelPkg::colour8_t inB [2];
	logic inValid [2];
	logic inMask [2];
	logic i_importStrobe;
	blockPkg::blockData_t i_importBlock;
	logic o_stencilWriteSig;
	blockPkg::blockAdr_t o_stencilWriteAdr;
	blockPkg::blockMask_t o_stencilWriteMask;
	blockPkg::blockMask_t o_stencilWriteValue;
	blockPkg::blockAdr_t o_loadAdr;
	blockPkg::blockAdr_t o_saveAdr;
	blockPkg::blockData_t o_exportBlock;
	blockPkg::blockMask_t o_exportMask;

	// --------------------------------------------------
	// Stimulus table
	// --------------------------------------------------
	logic tPause [NROWS];
	logic tFlush [NROWS];
	blockPkg::transition_t tTrans [NROWS];
	blockPkg::screenX_t tX [NROWS];
	blockPkg::screenY_t tY [NROWS];
	logic [7:0] tR [NROWS][2];
	logic [7:0] tG [NROWS][2];
	logic [7:0] tB [NROWS][2];
	logic tValid [NROWS][2];
	logic tMask [NROWS][2];
	// Blend controls act on the pair already in the stage
	logic tBlend [NROWS];
	pixelPkg::blendMode_t tMode [NROWS];
	logic tImport [NROWS];
	logic [1:0] tSel [NROWS];

	// Reference model, buffer side
	pixelPkg::pixelWord_t mBuf [16];
	blockPkg::blockMask_t mMask;
	blockPkg::blockAdr_t mLastAdr;
	// Reference model, stage side
	blockPkg::transition_t mTrans;
	blockPkg::screenX_t mX;
	blockPkg::screenY_t mY;
	logic [7:0] mR [2];
	logic [7:0] mG [2];
	logic [7:0] mB [2];
	logic mValid [2];
	logic mMaskBit [2];

	int seed;
	int failCount = 0;
	int cycleCount = 0;

	gpuBackend u_dut (
		.clk(clk), .i_rst(i_rst), .i_pause(i_pause), .i_flushClearMask(i_flushClearMask),
		.i_blendEnable(i_blendEnable), .i_blendMode(i_blendMode),
		.i_transition(i_transition), .i_scrX(i_scrX), .i_scrY(i_scrY),
		.i_rL(inR[0]), .i_gL(inG[0]), .i_bL(inB[0]),
		.i_rR(inR[1]), .i_gR(inG[1]), .i_bR(inB[1]),
		.i_validL(inValid[0]), .i_validR(inValid[1]),
		.i_maskL(inMask[0]), .i_maskR(inMask[1]),
		.i_importStrobe(i_importStrobe), .i_importBlock(i_importBlock),
		.o_stencilWriteSig(o_stencilWriteSig), .o_stencilWriteAdr(o_stencilWriteAdr),
		.o_stencilWriteMask(o_stencilWriteMask), .o_stencilWriteValue(o_stencilWriteValue),
		.o_loadAdr(o_loadAdr), .o_saveAdr(o_saveAdr),
		.o_exportBlock(o_exportBlock), .o_exportMask(o_exportMask)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	// Run limit
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CYCLE_LIMIT) begin
			$display("Timeout: the test did not finish within %0d cycles", CYCLE_LIMIT);
			$display("STATUS: FAIL");
			$fatal(1, "Run limit reached");
		end
	end

	// --------------------------------------------------
	// Expected values
	// --------------------------------------------------
	// Mode rules on one 5-bit channel, clamped to 0..31
	function automatic pixelPkg::colour5_t mixChannel(input pixelPkg::colour5_t bg,
			input pixelPkg::colour5_t fg, input pixelPkg::blendMode_t mode);
		int b;
		int f;
		int v;
		b = {27'd0, bg};
		f = {27'd0, fg};
		v = f;
		case (mode)
			pixelPkg::AVERAGE: v = b / 2 + f / 2;
			pixelPkg::ADD: v = b + f;
			pixelPkg::SUBTRACT: v = b - f;
			pixelPkg::ADD_QUARTER: v = b + f / 4;
		endcase
		if (v < 0) begin
			v = 0;
		end
		if (v > 31) begin
			v = 31;
		end
		return v[4:0];
	endfunction

	function automatic pixelPkg::pixelWord_t expectPixel(input logic [7:0] r, g, b,
			input logic m, input logic en, input pixelPkg::blendMode_t mode,
			input pixelPkg::pixelWord_t bg);
		pixelPkg::colour5_t cr;
		pixelPkg::colour5_t cg;
		pixelPkg::colour5_t cb;
		// Top 5 bits of each Gouraud channel
		cr = r[7:3];
		cg = g[7:3];
		cb = b[7:3];
		if (en) begin
			cr = mixChannel(bg[4:0], cr, mode);
			cg = mixChannel(bg[9:5], cg, mode);
			cb = mixChannel(bg[14:10], cb, mode);
		end
		return {m, cb, cg, cr};
	endfunction

	// Background fills, every field a function of the word index
	function automatic pixelPkg::pixelWord_t patternWord(input logic [1:0] sel, input logic [3:0] w);
		logic [4:0] w5;
		w5 = {1'b0, w};
		if (sel == 2'd1) begin
			// Red high for saturation, green low for clamp at 0
			return {w[0] ^ w[2], w5 + 5'd14, {2'b00, w[3:1]}, 5'd30 - w5};
		end else begin
			return {w[0], w5 + w5 + 5'd1, w5 + 5'd3, 5'd31 - w5};
		end
	endfunction

	function automatic blockPkg::blockData_t patternBlock(input logic [1:0] sel);
		blockPkg::blockData_t blk;
		for (int w = 0; w < 16; w++) begin
			blk[w*16 +: 16] = patternWord(sel, 4'(w));
		end
		return blk;
	endfunction

	// --------------------------------------------------
	// Table build
	// --------------------------------------------------
	task automatic setPair(input int r, input blockPkg::screenX_t x, input blockPkg::screenY_t y,
			input blockPkg::transition_t tr, input logic vL, input logic vR);
		tX[r] = x;
		tY[r] = y;
		tTrans[r] = tr;
		tValid[r][0] = vL;
		tValid[r][1] = vR;
	endtask

	task automatic buildTable();
		logic [31:0] rnd;
		// Idle rows with random payload
		for (int r = 0; r < NROWS; r++) begin
			rnd = $random(seed);
			tPause[r] = 1'b0;
			tFlush[r] = 1'b0;
			tTrans[r] = 2'b00;
			tX[r] = rnd[9:0];
			tY[r] = rnd[24:16];
			tBlend[r] = 1'b0;
			tMode[r] = pixelPkg::AVERAGE;
			tImport[r] = 1'b0;
			tSel[r] = 2'd0;
			for (int s = 0; s < 2; s++) begin
				rnd = $random(seed);
				tR[r][s] = rnd[7:0];
				tG[r][s] = rnd[15:8];
				tB[r][s] = rnd[23:16];
				tMask[r][s] = rnd[24];
				tValid[r][s] = 1'b0;
			end
		end
		// Opaque writes into block Y 5, X 2, the last one closes the block
		setPair(0, 10'h024, 9'd5, 2'b01, 1'b1, 1'b1);
		setPair(1, 10'h026, 9'd5, 2'b00, 1'b1, 1'b0);
		setPair(2, 10'h02E, 9'd5, 2'b00, 1'b0, 1'b1);
		setPair(3, 10'h020, 9'd5, 2'b00, 1'b0, 1'b0);
		setPair(4, 10'h02A, 9'd5, 2'b10, 1'b1, 1'b1);
		tFlush[6] = 1'b1;
		tImport[7] = 1'b1;
		tSel[7] = 2'd1;
		// Blend rows, full scale left and small right foreground
		for (int r = 8; r < 12; r++) begin
			setPair(r, 10'h030 + 10'(2 * (r - 8)), 9'd9, 2'b00, 1'b1, 1'b1);
			tR[r][0] = 8'hFF;
			tG[r][0] = 8'hFF;
			tB[r][0] = 8'hFF;
			tR[r][1] = 8'h08;
			tG[r][1] = 8'h80;
			tB[r][1] = 8'h40;
		end
		tTrans[8] = 2'b01;
		for (int r = 9; r < 13; r++) begin
			tBlend[r] = 1'b1;
		end
		tMode[9] = pixelPkg::AVERAGE;
		tMode[10] = pixelPkg::ADD;
		tMode[11] = pixelPkg::SUBTRACT;
		tMode[12] = pixelPkg::ADD_QUARTER;
		// Block end held in the stage across a pause
		setPair(13, 10'h038, 9'd9, 2'b10, 1'b1, 1'b1);
		tPause[14] = 1'b1;
		tPause[15] = 1'b1;
		setPair(15, 10'h040, 9'd9, 2'b01, 1'b1, 1'b1);
		// Source holds the same pair until pause drops
		setPair(16, 10'h040, 9'd9, 2'b01, 1'b1, 1'b1);
		for (int s = 0; s < 2; s++) begin
			tR[16][s] = tR[15][s];
			tG[16][s] = tG[15][s];
			tB[16][s] = tB[15][s];
			tMask[16][s] = tMask[15][s];
		end
		setPair(18, 10'h3FE, 9'h1FF, 2'b00, 1'b1, 1'b0);
		// Block end without pixels
		tTrans[20] = 2'b10;
	endtask

	task automatic driveRow(input int r);
		i_pause = tPause[r];
		i_flushClearMask = tFlush[r];
		i_transition = tTrans[r];
		i_scrX = tX[r];
		i_scrY = tY[r];
		i_blendEnable = tBlend[r];
		i_blendMode = tMode[r];
		i_importStrobe = tImport[r];
		i_importBlock = patternBlock(tSel[r]);
		for (int s = 0; s < 2; s++) begin
			inR[s] = tR[r][s];
			inG[s] = tG[r][s];
			inB[s] = tB[r][s];
			inValid[s] = tValid[r][s];
			inMask[s] = tMask[r][s];
		end
	endtask

	// --------------------------------------------------
	// Reference model
	// --------------------------------------------------
	task automatic resetModel();
		// Import runs during reset, the stage holds the zero inputs
		for (int w = 0; w < 16; w++) begin
			mBuf[w] = patternWord(2'd0, 4'(w));
		end
		mMask = '0;
		mLastAdr = '0;
		mTrans = '0;
		mX = '0;
		mY = '0;
		for (int s = 0; s < 2; s++) begin
			mR[s] = '0;
			mG[s] = '0;
			mB[s] = '0;
			mValid[s] = 1'b0;
			mMaskBit[s] = 1'b0;
		end
	endtask

	// One clock edge with row r on the inputs
	task automatic modelEdge(input int r);
		pixelPkg::pixelWord_t pix [2];
		logic [3:0] word [2];
		for (int s = 0; s < 2; s++) begin
			word[s] = {mX[3:1], 1'(s)};
			pix[s] = expectPixel(mR[s], mG[s], mB[s], mMaskBit[s], tBlend[r], tMode[r],
				mBuf[word[s]]);
		end
		// Import loads even while paused
		if (tImport[r]) begin
			for (int w = 0; w < 16; w++) begin
				mBuf[w] = patternWord(tSel[r], 4'(w));
			end
		end
		if (!tPause[r]) begin
			if (mTrans[blockPkg::TRANS_END] || tFlush[r]) begin
				mMask = '0;
			end
			for (int s = 0; s < 2; s++) begin
				if (mValid[s]) begin
					mBuf[word[s]] = pix[s];
					mMask[word[s]] = 1'b1;
					mLastAdr = {mY, mX[9:4]};
				end
			end
			mTrans = tTrans[r];
			mX = tX[r];
			mY = tY[r];
			for (int s = 0; s < 2; s++) begin
				mR[s] = tR[r][s];
				mG[s] = tG[r][s];
				mB[s] = tB[r][s];
				mValid[s] = tValid[r][s];
				mMaskBit[s] = tMask[r][s];
			end
		end
	endtask

	// --------------------------------------------------
	// Checks
	// --------------------------------------------------
	task automatic checkValue(input string name, input logic [255:0] got, input logic [255:0] exp);
		assert (got === exp) else begin
			failCount++;
			$display("CHECK FAILED at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
			$display("STATUS: FAIL");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	task automatic checkAll(input int r);
		blockPkg::blockData_t expBlock;
		blockPkg::blockMask_t expValue;
		logic expSig;
		for (int w = 0; w < 16; w++) begin
			expBlock[w*16 +: 16] = mBuf[w];
			expValue[w] = mBuf[w][15];
		end
		// Strobe follows the stage and the live pause level
		expSig = mTrans[blockPkg::TRANS_END] & ~tPause[r];
		checkValue("o_stencilWriteSig", 256'(o_stencilWriteSig), 256'(expSig));
		checkValue("o_stencilWriteAdr", 256'(o_stencilWriteAdr), 256'(mLastAdr));
		checkValue("o_saveAdr", 256'(o_saveAdr), 256'(mLastAdr));
		checkValue("o_loadAdr", 256'(o_loadAdr), 256'({mY, mX[9:4]}));
		checkValue("o_stencilWriteMask", 256'(o_stencilWriteMask), 256'(mMask));
		checkValue("o_exportMask", 256'(o_exportMask), 256'(mMask));
		checkValue("o_stencilWriteValue", 256'(o_stencilWriteValue), 256'(expValue));
		checkValue("o_exportBlock", o_exportBlock, expBlock);
	endtask

	// --------------------------------------------------
	// Main sequence
	// --------------------------------------------------
	initial begin
		seed = 32'h218c1fa9;
		buildTable();
		i_rst = 1'b1;
		i_pause = 1'b0;
		i_flushClearMask = 1'b0;
		i_transition = '0;
		i_scrX = '0;
		i_scrY = '0;
		i_blendEnable = 1'b0;
		i_blendMode = pixelPkg::AVERAGE;
		i_importStrobe = 1'b1;
		i_importBlock = patternBlock(2'd0);
		for (int s = 0; s < 2; s++) begin
			inR[s] = '0;
			inG[s] = '0;
			inB[s] = '0;
			inValid[s] = 1'b0;
			inMask[s] = 1'b0;
		end
		repeat (2) @(posedge clk);
		resetModel();
		for (int r = 0; r < NROWS; r++) begin
			#1;
			i_rst = 1'b0;
			driveRow(r);
			// Outputs settled from the last edge and this row's pause
			#2;
			checkAll(r);
			modelEdge(r);
			@(posedge clk);
		end
		if (failCount == 0) begin
			$display("STATUS: PASS");
			$finish;
		end else begin
			$display("STATUS: FAIL");
			$fatal(1, "Mismatches found");
		end
	end

endmodule

// File: backend.f
source/pixelPkg.sv
source/blockPkg.sv
source/pairStage.sv
source/pixelBlender.sv
source/blockBuffer.sv
source/gpuBackend.sv
dv/tbGpuBackend.sv

// File: Makefile
# Verilator build and run of the pixel back end testbench
VERILATOR ?= verilator
TOP ?= tbGpuBackend
FILELIST ?= backend.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0

SOURCES := $(wildcard source/*.sv) $(wildcard dv/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx 'STATUS: PASS'

clean:
	rm -rf $(OBJ_DIR)
